// ==== logic/fir_defs.svh ====
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// Datapath widths.
`define FIR_SAMPLE_W  16
`define FIR_COEFF_W   16
`define FIR_PRODUCT_W 32
`define FIR_SUM_W     33

`define FIR_TAPS 8

// Symmetric low-pass taps. Coefficient 1 sits on the newest sample.
`define FIR_COEFF_1 16'hDDBB // -8773.
`define FIR_COEFF_2 16'hEA8E // -5490.
`define FIR_COEFF_3 16'h33DB // 13275.
`define FIR_COEFF_4 16'h6808 // 26632.
`define FIR_COEFF_5 16'h6808
`define FIR_COEFF_6 16'h33DB
`define FIR_COEFF_7 16'hEA8E
`define FIR_COEFF_8 16'hDDBB

`endif

// ==== logic/fir_pkg.sv ====
`include "fir_defs.svh"

package fir_pkg;

  typedef logic signed [`FIR_SAMPLE_W-1:0]  sample_t;
  typedef logic signed [`FIR_COEFF_W-1:0]   coeff_t;
  typedef logic signed [`FIR_PRODUCT_W-1:0] product_t;
  typedef logic signed [`FIR_SUM_W-1:0]     sum_t;

  // One entry per delay stage, newest at index 0.
  typedef sample_t  tap_array_t [`FIR_TAPS];
  typedef product_t product_array_t [`FIR_TAPS];

endpackage

// ==== logic/carry_skip_adder.sv ====
module carry_skip_adder #(
  parameter int width = 8
) (
  input  logic [width-1:0] x,
  input  logic [width-1:0] y,
  output logic [width-1:0] sum
);

  logic             carry_in;
  logic [width-1:0] propagate;
  logic [width-1:0] ripple;    // Carry into each bit.
  logic             skip_all;
  logic             msb_carry;

  assign carry_in  = 1'b0;
  assign propagate = x ^ y;
  assign ripple[0] = carry_in;

  // Full-adder cells below the top bit.
  genvar i;
  generate
    for (i = 0; i < width - 1; i++) begin : g_cell
      assign sum[i]      = propagate[i] ^ ripple[i];
      assign ripple[i+1] = (x[i] & y[i]) | (propagate[i] & ripple[i]);
    end
  endgenerate

  // When every lower bit propagates, the carry-in skips straight to the top.
  assign skip_all  = &propagate[width-2:0];
  assign msb_carry = skip_all ? carry_in : ripple[width-1];

  // Carry out of the top bit is dropped. Sum wraps.
  assign sum[width-1] = propagate[width-1] ^ msb_carry;

endmodule

// ==== logic/vedic_multiplier.sv ====
module vedic_multiplier #(
  parameter int width = 16
) (
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  output logic [2*width-1:0] result
);

  generate
    if (width == 2) begin : g_base
      logic a1_b0;
      logic a0_b1;
      logic a1_b1;
      logic carry_1;

      assign result[0] = a[0] & b[0];
      assign a1_b0     = a[1] & b[0];
      assign a0_b1     = a[0] & b[1];
      assign a1_b1     = a[1] & b[1];

      // First half adder on the cross terms.
      assign result[1] = a1_b0 ^ a0_b1;
      assign carry_1   = a1_b0 & a0_b1;

      assign result[2] = a1_b1 ^ carry_1; // Second half adder.
      assign result[3] = a1_b1 & carry_1;
    end else begin : g_split
      localparam int half = width / 2;

      logic [width-1:0]      q0;        // Low by low.
      logic [width-1:0]      q1;        // High a by low b.
      logic [width-1:0]      q2;        // Low a by high b.
      logic [width-1:0]      q3;        // High by high.
      logic [width-1:0]      mid_sum;
      logic [width+half-1:0] cross_sum;
      logic [width+half-1:0] upper_sum;

      vedic_multiplier #(.width(half)) u_lo_lo (
        .a      (a[half-1:0]),
        .b      (b[half-1:0]),
        .result (q0)
      );

      vedic_multiplier #(.width(half)) u_hi_lo (
        .a      (a[width-1:half]),
        .b      (b[half-1:0]),
        .result (q1)
      );

      vedic_multiplier #(.width(half)) u_lo_hi (
        .a      (a[half-1:0]),
        .b      (b[width-1:half]),
        .result (q2)
      );

      vedic_multiplier #(.width(half)) u_hi_hi (
        .a      (a[width-1:half]),
        .b      (b[width-1:half]),
        .result (q3)
      );

      // Upper half of q0 joins q1; cannot overflow width bits.
      carry_skip_adder #(.width(width)) u_add_mid (
        .x   ({{half{1'b0}}, q0[width-1:half]}),
        .y   (q1),
        .sum (mid_sum)
      );

      carry_skip_adder #(.width(width + half)) u_add_cross (
        .x   ({{half{1'b0}}, q2}),
        .y   ({q3, {half{1'b0}}}),
        .sum (cross_sum)
      );

      carry_skip_adder #(.width(width + half)) u_add_upper (
        .x   ({{half{1'b0}}, mid_sum}),
        .y   (cross_sum),
        .sum (upper_sum)
      );

      assign result = {upper_sum, q0[half-1:0]}; // Low bits pass straight.
    end
  endgenerate

endmodule

// ==== logic/signed_tap_multiplier.sv ====
`include "fir_defs.svh"

module signed_tap_multiplier
  import fir_pkg::*;
(
  input  sample_t  sample,
  input  coeff_t   coeff,
  output product_t product
);

  logic                        sample_neg;
  logic                        coeff_neg;
  logic                        negate;
  logic [`FIR_SAMPLE_W-1:0]    sample_mag;
  logic [`FIR_COEFF_W-1:0]     coeff_mag;
  logic [`FIR_PRODUCT_W-1:0]   product_mag;

  assign sample_neg = sample[`FIR_SAMPLE_W-1];
  assign coeff_neg  = coeff[`FIR_COEFF_W-1];
  assign negate     = sample_neg ^ coeff_neg;

  // Magnitude of -32768 comes out as 16'h8000.
  assign sample_mag = sample_neg ? -sample : sample;
  assign coeff_mag  = coeff_neg ? -coeff : coeff;

  // Unsigned core on the magnitudes.
  vedic_multiplier #(
    .width (`FIR_SAMPLE_W)
  ) u_core (
    .a      (sample_mag),
    .b      (coeff_mag),
    .result (product_mag)
  );

  // Magnitude is at most 2**30, so the signed result always fits.
  assign product = negate ? -product_t'(product_mag) : product_t'(product_mag);

endmodule

// ==== logic/tap_delay_line.sv ====
`include "fir_defs.svh"

module tap_delay_line
  import fir_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       clk_enable,
  input  sample_t    filter_in,
  output tap_array_t taps
);

  // Shift on enabled edges only; hold otherwise.
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `FIR_TAPS; i++) begin
        taps[i] <= '0;
      end
    end else if (clk_enable) begin
      taps[0] <= filter_in; // Newest sample.
      for (int i = 1; i < `FIR_TAPS; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

endmodule

// ==== logic/tap_accumulator.sv ====
`include "fir_defs.svh"

module tap_accumulator
  import fir_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           clk_enable,
  input  product_array_t products,
  output sum_t           filter_out
);

  sum_t extended [`FIR_TAPS];
  sum_t partial  [`FIR_TAPS]; // Running sum after each tap.

  genvar k;
  generate
    for (k = 0; k < `FIR_TAPS; k++) begin : g_extend
      assign extended[k] = sum_t'(products[k]); // Sign extension.
    end
  endgenerate

  assign partial[0] = extended[0];

  // Seven adders in tap order.
  generate
    for (k = 1; k < `FIR_TAPS; k++) begin : g_chain
      carry_skip_adder #(
        .width (`FIR_SUM_W)
      ) u_add (
        .x   (partial[k-1]),
        .y   (extended[k]),
        .sum (partial[k])
      );
    end
  endgenerate

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      filter_out <= '0;
    end else if (clk_enable) begin
      filter_out <= partial[`FIR_TAPS-1];
    end
  end

endmodule

// ==== logic/fir_filter.sv ====
`include "fir_defs.svh"

module fir_filter
  import fir_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    clk_enable,
  input  sample_t filter_in,
  output sum_t    filter_out
);

  tap_array_t     taps;
  product_array_t products;
  coeff_t         coeffs [`FIR_TAPS];

  assign coeffs[0] = `FIR_COEFF_1; // Newest sample.
  assign coeffs[1] = `FIR_COEFF_2;
  assign coeffs[2] = `FIR_COEFF_3;
  assign coeffs[3] = `FIR_COEFF_4;
  assign coeffs[4] = `FIR_COEFF_5;
  assign coeffs[5] = `FIR_COEFF_6;
  assign coeffs[6] = `FIR_COEFF_7;
  assign coeffs[7] = `FIR_COEFF_8; // Oldest sample.

  tap_delay_line u_delay_line (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .taps       (taps)
  );

  genvar k;
  generate
    for (k = 0; k < `FIR_TAPS; k++) begin : g_tap
      signed_tap_multiplier u_mult (
        .sample  (taps[k]),
        .coeff   (coeffs[k]),
        .product (products[k])
      );
    end
  endgenerate

  // Adder chain and output register.
  tap_accumulator u_accumulator (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .products   (products),
    .filter_out (filter_out)
  );

endmodule

// ==== test/fir_filter_asserts.sv ====
`include "fir_defs.svh"

module fir_filter_asserts
  import fir_pkg::*;
(
  input logic           clk,
  input logic           reset,
  input logic           clk_enable,
  input sum_t           filter_out,
  input tap_array_t     taps,
  input coeff_t         coeffs [`FIR_TAPS],
  input product_array_t products
);

  int failures = 0;

  // Output register holds on disabled edges.
  hold_when_disabled: assert property (
    @(posedge clk) disable iff (reset) !clk_enable |=> $stable(filter_out)
  ) else begin
    $error("filter_out changed after an edge with clk_enable low");
    failures++;
  end

  zero_in_reset: assert property (@(posedge clk) reset |-> filter_out == '0)
    else begin
      $error("filter_out is not zero while reset is high");
      failures++;
    end

  // Each tap multiplier gives the exact signed product.
  genvar k;
  generate
    for (k = 0; k < `FIR_TAPS; k++) begin : g_product
      exact_product: assert property (
        @(posedge clk) products[k] == product_t'(taps[k]) * product_t'(coeffs[k])
      ) else begin
        $error("tap %0d multiplier gave a wrong signed product", k);
        failures++;
      end
    end
  endgenerate

endmodule

bind fir_filter fir_filter_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .clk_enable (clk_enable),
  .filter_out (filter_out),
  .taps       (taps),
  .coeffs     (coeffs),
  .products   (products)
);

// ==== test/fir_filter_tb.sv ====
`include "fir_defs.svh"

module fir_filter_tb
  import fir_pkg::*;
();

  // Reset, idle, three impulses, two random streams, mid-stream reset.
  localparam int test_cycles = 2 + 7 + 3 * 12 + 200 + 200 + 43;

  logic    clk;
  logic    reset;
  logic    clk_enable;
  sample_t filter_in;
  sum_t    filter_out;

  integer  seed = 32'h36b8;
  int      errors = 0;
  int      checks = 0;

  // Reference model state.
  int      coeff_table [`FIR_TAPS] = '{-8773, -5490, 13275, 26632,
                                       26632, 13275, -5490, -8773};
  sample_t hist [`FIR_TAPS];
  sum_t    expected;
  logic    drv_en;   // Values the DUT sees at the next edge.
  sample_t drv_in;

  fir_filter DUT (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out)
  );

  always #10 clk = ~clk;

  function automatic sum_t model_sum();
    longint acc;
    acc = 0;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      acc += longint'(coeff_table[k]) * longint'(hist[k]);
    end
    return sum_t'(acc);
  endfunction

  task automatic model_edge();
    if (drv_en) begin
      expected = model_sum(); // Output sees the taps before the shift.
      for (int k = `FIR_TAPS - 1; k > 0; k--) begin
        hist[k] = hist[k-1];
      end
      hist[0] = drv_in;
    end
  endtask

  task automatic model_clear();
    for (int k = 0; k < `FIR_TAPS; k++) begin
      hist[k] = '0;
    end
    expected = '0;
  endtask

  task automatic check_sum(input sum_t got, input sum_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error filter_out: got %h, expected %h at %0t", got, want, $time);
    end
  endtask

  // Drives one clock and checks the output mid-cycle.
  task automatic step(input sample_t s, input logic en);
    @(posedge clk);
    model_edge();
    filter_in  <= s;
    clk_enable <= en;
    drv_in = s;
    drv_en = en;
    @(negedge clk);
    check_sum(filter_out, expected);
  endtask

  task automatic test_reset_idle();
    @(negedge clk);
    check_sum(filter_out, '0);
    repeat (6) step('0, 1'b1);
  endtask

  task automatic test_impulse(input sample_t value);
    sum_t want;
    step(value, 1'b1);
    for (int n = 0; n < 11; n++) begin
      step('0, 1'b1);
      if (n >= 1 && n <= `FIR_TAPS) begin
        want = sum_t'(longint'(coeff_table[n-1]) * longint'(value));
      end else begin
        want = '0;
      end
      check_sum(filter_out, want);
    end
  endtask

  task automatic test_random_stream(input int count, input bit toggle_enable);
    sample_t s;
    logic    en;
    repeat (count) begin
      s  = sample_t'($random(seed));
      en = toggle_enable ? 1'($random(seed)) : 1'b1;
      step(s, en);
    end
  endtask

  task automatic test_mid_reset();
    test_random_stream(20, 1'b0);
    @(posedge clk);
    model_edge(); // This edge still shifts before reset rises.
    reset      <= 1'b1;
    clk_enable <= 1'b0;
    filter_in  <= '0;
    drv_en = 1'b0;
    drv_in = '0;
    model_clear();
    @(negedge clk);
    check_sum(filter_out, '0);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    test_random_stream(20, 1'b0);
  endtask

  initial begin
    clk        = 1'b0;
    reset      <= 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    drv_en     = 1'b0;
    drv_in     = '0;
    model_clear();
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    test_reset_idle();
    test_impulse(16'sd1);
    test_impulse(-16'sd32768);
    test_impulse(16'sd32767);
    test_random_stream(200, 1'b0);
    test_random_stream(200, 1'b1);
    test_mid_reset();

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_asserts.failures);
    if (errors == 0 && DUT.u_asserts.failures == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(20 * (test_cycles + 100));
    $display("timeout: the tests did not finish in the expected time");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== fir_filter.f ====
+incdir+logic
logic/fir_pkg.sv
logic/carry_skip_adder.sv
logic/vedic_multiplier.sv
logic/signed_tap_multiplier.sv
logic/tap_delay_line.sv
logic/tap_accumulator.sv
logic/fir_filter.sv
test/fir_filter_asserts.sv
test/fir_filter_tb.sv

// ==== Makefile ====
SOURCES := fir_filter.f $(wildcard logic/*.sv logic/*.svh test/*.sv)

all: run

# Rebuilt only when a source or the file list changes.
obj_dir/V%: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f fir_filter.f \
		--top-module $* -Mdir obj_dir

run: obj_dir/Vfir_filter_tb
	obj_dir/Vfir_filter_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
